/* tb.f */
design/ex_pkg.sv
design/alu_control.sv
design/alu.sv
design/muldiv_core.sv
design/iter_counter.sv
design/ex_fsm.sv
design/ex_unit_top.sv
verif/ex_unit_chk.sv
verif/tb_ex_unit.sv

/* run.sh */
#!/bin/sh
# build the ex_unit testbench with verilator, run it, judge from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_unit \
	-f tb.f -o sim_ex_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_ex_unit > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
	echo "FAIL"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
echo "PASS"
exit 0

/* verif/tb_ex_unit.sv */
`timescale 1ns/100ps

module tb_ex_unit import ex_pkg::*; ();

	localparam int DATA_W = 32;
	localparam int CLK_PERIOD = 40;
	localparam int SEED = 75366;

	// one table row with fixed operands or ones drawn at apply time
	typedef struct {
		alu_op_t           op;
		logic [5:0]        fn;
		logic [4:0]        sh;
		bit                rnd; // operands from $urandom and expected values from the model
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		alu_ctl_t          ctl; // decoder output
		logic [DATA_W-1:0] res;
		bit                br;
	} entry_t;

	logic              clk;
	logic              rst_n;
	logic              cyc;
	logic              stb;
	alu_op_t           alu_op;
	logic [5:0]        funct;
	logic [4:0]        shamt;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic              ack;
	logic [DATA_W-1:0] result;
	logic              branch;

	entry_t            tbl[$];
	bit                tbl_ready = 1'b0;
	int                cur = 0;  // entry in flight
	logic [DATA_W-1:0] m_hi;     // model copies of hi/lo
	logic [DATA_W-1:0] m_lo;

	ex_unit_top #(.DATA_W(DATA_W)) uut (
		.clk    (clk),
		.rst_n  (rst_n),
		.cyc    (cyc),
		.stb    (stb),
		.alu_op (alu_op),
		.funct  (funct),
		.shamt  (shamt),
		.op_a   (op_a),
		.op_b   (op_b),
		.ack    (ack),
		.result (result),
		.branch (branch)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_result(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t: result = %h, expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_branch(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t: branch = %b, expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_ctl(input alu_ctl_t got, input alu_ctl_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t: uut.u_ctl.ctl = %b, expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp)
		begin
			$display("[ERROR] %0t: ack latency = %0d, expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic add_entry(input alu_op_t op, input logic [5:0] fn, input logic [4:0] sh,
		input bit rnd, input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
		input alu_ctl_t ctl, input logic [DATA_W-1:0] res, input bit br);
		tbl.push_back('{op, fn, sh, rnd, a, b, ctl, res, br});
	endtask

	// reference behavior with hi/lo kept across calls
	task automatic run_model(input alu_ctl_t c, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [4:0] sh,
		output logic [DATA_W-1:0] res, output logic br);
		logic [2*DATA_W-1:0] prod;
		prod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b}; // unsigned full product
		if (c == CTL_MULT)
			{m_hi, m_lo} = prod;
		if (c == CTL_DIV)
			{m_hi, m_lo} = (b == '0) ? {a, {DATA_W{1'b1}}} : {a % b, a / b};
		case (c)
			CTL_ADD: res = a + b;
			CTL_SUB, CTL_SUBNE: res = a - b;
			CTL_SLT: res = (a < b) ? 1 : 0;
			CTL_AND: res = a & b;
			CTL_OR: res = a | b;
			CTL_NOR: res = ~(a | b);
			CTL_SLL: res = b << sh;
			CTL_SRL: res = b >> sh;
			CTL_MULT, CTL_DIV, CTL_MFLO: res = m_lo; // fresh low half or quotient
			CTL_MUL: res = prod[DATA_W-1:0];
			CTL_MFHI: res = m_hi;
			default: res = '0;
		endcase
		br = ((c == CTL_SUB) && (a == b)) || ((c == CTL_SUBNE) && (a != b));
	endtask

	task automatic build_table();
		// hi/lo read back their reset value
		add_entry(ALUOP_RTYPE, FN_MFHI, 0, 0, 32'h0, 32'h0, CTL_MFHI, 32'h0, 0);
		add_entry(ALUOP_RTYPE, FN_MFLO, 0, 0, 32'h0, 32'h0, CTL_MFLO, 32'h0, 0);
		// single-cycle edge values through both decoder paths
		add_entry(ALUOP_ADD, 0, 0, 0, 32'h7fffffff, 32'h1, CTL_ADD, 32'h80000000, 0);
		add_entry(ALUOP_RTYPE, FN_ADD, 0, 0, 32'hffffffff, 32'h1, CTL_ADD, 32'h0, 0);
		add_entry(ALUOP_RTYPE, FN_SUB, 0, 0, 32'h5, 32'h7, CTL_SUB, 32'hfffffffe, 0);
		add_entry(ALUOP_RTYPE, FN_AND, 0, 0, 32'hf0f0f0f0, 32'hff00ff00, CTL_AND, 32'hf000f000, 0);
		add_entry(ALUOP_AND, 0, 0, 0, 32'h12345678, 32'h0000ffff, CTL_AND, 32'h00005678, 0);
		add_entry(ALUOP_RTYPE, FN_OR, 0, 0, 32'hf0f0f0f0, 32'h0f0f0000, CTL_OR, 32'hfffff0f0, 0);
		add_entry(ALUOP_OR, 0, 0, 0, 32'ha0000000, 32'h5, CTL_OR, 32'ha0000005, 0);
		add_entry(ALUOP_RTYPE, FN_NOR, 0, 0, 32'hf0f0f0f0, 32'h0f0f0f0f, CTL_NOR, 32'h0, 0);
		add_entry(ALUOP_RTYPE, FN_SLT, 0, 0, 32'h1, 32'hffffffff, CTL_SLT, 32'h1, 0);
		add_entry(ALUOP_SLT, 0, 0, 0, 32'hffffffff, 32'h1, CTL_SLT, 32'h0, 0);
		add_entry(ALUOP_RTYPE, FN_SLL, 4, 0, 32'h0, 32'h8000000f, CTL_SLL, 32'hf0, 0);
		add_entry(ALUOP_RTYPE, FN_SRL, 31, 0, 32'h0, 32'h80000000, CTL_SRL, 32'h1, 0);
		// branch compares
		add_entry(ALUOP_BEQ, 0, 0, 0, 32'h1234, 32'h1234, CTL_SUB, 32'h0, 1);
		add_entry(ALUOP_BEQ, 0, 0, 0, 32'h1234, 32'h1235, CTL_SUB, 32'hffffffff, 0);
		add_entry(ALUOP_BNE, 0, 0, 0, 32'h1234, 32'h1235, CTL_SUBNE, 32'hffffffff, 1);
		add_entry(ALUOP_BNE, 0, 0, 0, 32'habcd, 32'habcd, CTL_SUBNE, 32'h0, 0);
		// multiply then hi/lo reads
		add_entry(ALUOP_RTYPE, FN_MULT, 0, 0, 32'hffffffff, 32'hffffffff, CTL_MULT, 32'h1, 0);
		add_entry(ALUOP_RTYPE, FN_MFHI, 0, 0, 32'h0, 32'h0, CTL_MFHI, 32'hfffffffe, 0);
		add_entry(ALUOP_RTYPE, FN_MFLO, 0, 0, 32'h0, 32'h0, CTL_MFLO, 32'h1, 0);
		add_entry(ALUOP_RTYPE, FN_MUL, 0, 0, 32'h00012345, 32'h10000, CTL_MUL, 32'h23450000, 0);
		add_entry(ALUOP_RTYPE, FN_MFHI, 0, 0, 32'h0, 32'h0, CTL_MFHI, 32'hfffffffe, 0);
		add_entry(ALUOP_RTYPE, FN_MFLO, 0, 0, 32'h0, 32'h0, CTL_MFLO, 32'h1, 0);
		// divide by a normal divisor and by zero
		add_entry(ALUOP_RTYPE, FN_DIV, 0, 0, 32'd100, 32'd7, CTL_DIV, 32'd14, 0);
		add_entry(ALUOP_RTYPE, FN_MFHI, 0, 0, 32'h0, 32'h0, CTL_MFHI, 32'd2, 0);
		add_entry(ALUOP_RTYPE, FN_MFLO, 0, 0, 32'h0, 32'h0, CTL_MFLO, 32'd14, 0);
		add_entry(ALUOP_RTYPE, FN_DIV, 0, 0, 32'hdeadbeef, 32'h0, CTL_DIV, 32'hffffffff, 0);
		add_entry(ALUOP_RTYPE, FN_MFHI, 0, 0, 32'h0, 32'h0, CTL_MFHI, 32'hdeadbeef, 0);
		add_entry(ALUOP_RTYPE, FN_MFLO, 0, 0, 32'h0, 32'h0, CTL_MFLO, 32'hffffffff, 0);
		// no-op codes
		add_entry(ALUOP_RTYPE, FN_JR, 0, 0, 32'h5, 32'h6, CTL_NOP, 32'h0, 0);
		add_entry(ALUOP_NONE, 0, 0, 0, 32'h5, 32'h6, CTL_NOP, 32'h0, 0);
		add_entry(ALUOP_RTYPE, 6'h3f, 0, 0, 32'h5, 32'h6, CTL_NOP, 32'h0, 0);
		// random operands checked against run_model
		add_entry(ALUOP_RTYPE, FN_ADD, 0, 1, 0, 0, CTL_ADD, 0, 0);
		add_entry(ALUOP_RTYPE, FN_SUB, 0, 1, 0, 0, CTL_SUB, 0, 0);
		add_entry(ALUOP_RTYPE, FN_AND, 0, 1, 0, 0, CTL_AND, 0, 0);
		add_entry(ALUOP_RTYPE, FN_OR, 0, 1, 0, 0, CTL_OR, 0, 0);
		add_entry(ALUOP_RTYPE, FN_NOR, 0, 1, 0, 0, CTL_NOR, 0, 0);
		add_entry(ALUOP_RTYPE, FN_SLT, 0, 1, 0, 0, CTL_SLT, 0, 0);
		add_entry(ALUOP_RTYPE, FN_SLL, 7, 1, 0, 0, CTL_SLL, 0, 0);
		add_entry(ALUOP_RTYPE, FN_SRL, 13, 1, 0, 0, CTL_SRL, 0, 0);
		add_entry(ALUOP_RTYPE, FN_MULT, 0, 1, 0, 0, CTL_MULT, 0, 0);
		add_entry(ALUOP_RTYPE, FN_MFHI, 0, 1, 0, 0, CTL_MFHI, 0, 0);
		add_entry(ALUOP_RTYPE, FN_DIV, 0, 1, 0, 0, CTL_DIV, 0, 0);
		add_entry(ALUOP_RTYPE, FN_MFLO, 0, 1, 0, 0, CTL_MFLO, 0, 0);
		add_entry(ALUOP_RTYPE, FN_MUL, 0, 1, 0, 0, CTL_MUL, 0, 0);
		add_entry(ALUOP_RTYPE, FN_MFHI, 0, 1, 0, 0, CTL_MFHI, 0, 0);
	endtask

	// an entry takes at most DATA_W+4 cycles
	initial
	begin
		wait (tbl_ready);
		#(tbl.size() * (DATA_W + 4) * CLK_PERIOD * 2);
		$display("timeout: ack never came for table entry %0d", cur);
		abort_run();
	end

	initial
	begin
		entry_t            e;
		int                cycles;
		logic [DATA_W-1:0] exp_res;
		logic              exp_br;
		void'($urandom(SEED));
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		alu_op = ALUOP_NONE;
		funct = '0;
		shamt = '0;
		op_a = '0;
		op_b = '0;
		m_hi = '0; // hi/lo clear out of reset
		m_lo = '0;
		build_table();
		tbl_ready = 1'b1;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
		@(posedge clk);
		#2;
		check_result(result, '0); // result reg clear out of reset
		check_branch(branch, 1'b0);
		for (int i = 0; i < tbl.size(); i++)
		begin
			cur = i;
			e = tbl[i];
			if (e.rnd)
			begin
				e.a = $urandom();
				e.b = $urandom();
			end
			alu_op = e.op;
			funct = e.fn;
			shamt = e.sh;
			op_a = e.a;
			op_b = e.b;
			cyc = 1'b1;
			stb = 1'b1; // held until ack
			run_model(e.ctl, e.a, e.b, e.sh, exp_res, exp_br);
			if (!e.rnd)
			begin
				exp_res = e.res;
				exp_br = e.br;
			end
			cycles = 0;
			do
			begin
				@(negedge clk); // mid-cycle sample
				cycles++;
			end
			while (!ack);
			check_ctl(uut.u_ctl.ctl, e.ctl);
			check_result(result, exp_res);
			check_branch(branch, exp_br);
			check_latency(cycles - 1, (e.ctl inside {CTL_MULT, CTL_MUL, CTL_DIV}) ? DATA_W + 2 : 1);
			@(posedge clk);
			#2;
			// stb stays high between most entries with an idle gap every fifth
			if (i % 5 == 4)
			begin
				cyc = 1'b0;
				stb = 1'b0;
				@(posedge clk);
				#2;
			end
		end
		cyc = 1'b0;
		stb = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		if (uut.u_chk.fail_cnt == 0)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			$display("%0d assertion failures in ex_unit_chk", uut.u_chk.fail_cnt);
			abort_run();
		end
	end

endmodule

/* verif/ex_unit_chk.sv */
`timescale 1ns/100ps

module ex_unit_chk import ex_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     cyc,
	input logic     stb,
	input logic     ack,
	input logic     step,   // fsm iterating
	input logic     finish, // fsm committing hi/lo
	input alu_ctl_t ctl
);

	logic idle; // fsm in idle when none of its state flags is up
	logic single;
	int   fail_cnt = 0; // failing assertions so far

	assign idle = !ack && !step && !finish;
	assign single = (ctl != CTL_MULT) && (ctl != CTL_MUL) && (ctl != CTL_DIV);

	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
		else
		begin
			$error("ack held high for more than one cycle");
			fail_cnt++;
		end

	// ack only answers a live request
	a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(cyc && stb))
		else
		begin
			$error("ack rose without cyc and stb");
			fail_cnt++;
		end

	a_ack_reset: assert property (@(posedge clk) !rst_n |-> !ack)
		else
		begin
			$error("ack high during reset");
			fail_cnt++;
		end

	a_single_lat: assert property (@(posedge clk) disable iff (!rst_n)
		idle && cyc && stb && single |=> ack)
		else
		begin
			$error("single-cycle request not acknowledged in the next cycle");
			fail_cnt++;
		end

endmodule

bind ex_unit_top ex_unit_chk u_chk (
	.clk    (clk),
	.rst_n  (rst_n),
	.cyc    (cyc),
	.stb    (stb),
	.ack    (ack),
	.step   (step),
	.finish (finish),
	.ctl    (ctl)
);

/* design/ex_unit_top.sv */
`timescale 1ns/100ps

module ex_unit_top import ex_pkg::*; #(
	parameter int DATA_W = EX_DATA_W
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cyc,
	input  logic              stb,
	input  alu_op_t           alu_op,
	input  logic [5:0]        funct,
	input  logic [4:0]        shamt,
	input  logic [DATA_W-1:0] op_a,
	input  logic [DATA_W-1:0] op_b,
	output logic              ack,
	output logic [DATA_W-1:0] result,
	output logic              branch
);

	alu_ctl_t          ctl;
	logic              load;
	logic              step;
	logic              finish;
	logic              last;
	logic [DATA_W-1:0] hi;
	logic [DATA_W-1:0] lo;
	logic [DATA_W-1:0] prod_lo;
	logic [DATA_W-1:0] alu_y;
	logic              alu_br;
	logic              res_en;

	alu_control u_ctl (
		.alu_op (alu_op),
		.funct  (funct),
		.ctl    (ctl)
	);

	alu #(.DATA_W(DATA_W)) u_alu (
		.ctl     (ctl),
		.op_a    (op_a),
		.op_b    (op_b),
		.shamt   (shamt),
		.hi      (hi),
		.lo      (lo),
		.prod_lo (prod_lo),
		.y       (alu_y),
		.branch  (alu_br)
	);

	muldiv_core #(.DATA_W(DATA_W)) u_muldiv (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctl     (ctl),
		.op_a    (op_a),
		.op_b    (op_b),
		.load    (load),
		.step    (step),
		.finish  (finish),
		.hi      (hi),
		.lo      (lo),
		.prod_lo (prod_lo)
	);

	iter_counter #(.DATA_W(DATA_W)) u_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (load),
		.step  (step),
		.last  (last)
	);

	ex_fsm u_fsm (
		.clk    (clk),
		.rst_n  (rst_n),
		.cyc    (cyc),
		.stb    (stb),
		.ctl    (ctl),
		.last   (last),
		.load   (load),
		.step   (step),
		.finish (finish),
		.ack    (ack)
	);

	// track alu while a request waits, freeze on the edge ack rises
	assign res_en = cyc && stb && !ack;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			result <= '0;
			branch <= 1'b0;
		end
		else if (res_en)
		begin
			result <= alu_y;
			branch <= alu_br;
		end
	end

endmodule

/* design/ex_fsm.sv */
`timescale 1ns/100ps

module ex_fsm import ex_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     cyc,
	input  logic     stb,
	input  alu_ctl_t ctl,
	input  logic     last,   // from iter_counter
	output logic     load,
	output logic     step,
	output logic     finish,
	output logic     ack     // registered, one cycle
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ITER,
		S_FIN,
		S_ACK
	} state_t;

	state_t state;
	state_t state_nx;
	logic   req;
	logic   iter_op;

	assign req = cyc && stb;
	assign iter_op = is_iterative(ctl);

	always_comb
	begin
		state_nx = state;
		case (state)
			S_IDLE:
				if (req)
					state_nx = iter_op ? S_ITER : S_ACK; // single-cycle codes skip ahead
			S_ITER:
				if (last)
					state_nx = S_FIN;
			S_FIN:
				state_nx = S_ACK;
			S_ACK:
				state_nx = S_IDLE; // stb still high here, don't sample it
			default:
				state_nx = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			ack <= 1'b0;
		end
		else
		begin
			state <= state_nx;
			ack <= (state_nx == S_ACK);
		end
	end

	assign load = (state == S_IDLE) && req && iter_op; // operands into accumulator
	assign step = (state == S_ITER);
	assign finish = (state == S_FIN);

endmodule

/* design/iter_counter.sv */
`timescale 1ns/100ps

module iter_counter import ex_pkg::*; #(
	parameter int DATA_W = EX_DATA_W
) (
	input  logic clk,
	input  logic rst_n,
	input  logic load, // start of an iterative op
	input  logic step,
	output logic last  // final iteration in progress
);

	localparam int CNT_W = $clog2(DATA_W);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (load)
			cnt <= CNT_W'(DATA_W - 1);
		else if (step && !last)
			cnt <= cnt - 1'b1; // parks at zero
	end

	assign last = (cnt == '0);

endmodule

/* design/muldiv_core.sv */
`timescale 1ns/100ps

module muldiv_core import ex_pkg::*; #(
	parameter int DATA_W = EX_DATA_W
) (
	input  logic              clk,
	input  logic              rst_n,
	input  alu_ctl_t          ctl,     // held by the master for the whole op
	input  logic [DATA_W-1:0] op_a,
	input  logic [DATA_W-1:0] op_b,
	input  logic              load,    // capture operands
	input  logic              step,    // one bit of work
	input  logic              finish,  // commit to hi/lo or prod_lo
	output logic [DATA_W-1:0] hi,
	output logic [DATA_W-1:0] lo,
	output logic [DATA_W-1:0] prod_lo
);

	logic [2*DATA_W-1:0] acc;      // {upper, lower} working pair
	logic [DATA_W-1:0]   opnd;     // multiplicand or divisor
	logic [2*DATA_W-1:0] acc_next;
	logic [DATA_W:0]     add_sum;  // upper plus carry out
	logic [DATA_W:0]     rem_sh;   // partial remainder after the shift
	logic [DATA_W+1:0]   rem_diff; // msb set means restore
	logic [DATA_W-1:0]   hi_q;
	logic [DATA_W-1:0]   lo_q;
	logic [DATA_W-1:0]   pl_q;
	logic                is_div;
	logic                commit_hl;
	logic                commit_pl;

	assign is_div = (ctl == CTL_DIV);
	assign commit_hl = finish && (ctl != CTL_MUL); // mult and div
	assign commit_pl = finish && (ctl == CTL_MUL);

	// multiply: add opnd when the multiplier lsb is set
	assign add_sum = {1'b0, acc[2*DATA_W-1:DATA_W]} +
		{1'b0, opnd & {DATA_W{acc[0]}}};

	// divide: shift in next dividend bit, try subtract
	assign rem_sh = acc[2*DATA_W-1:DATA_W-1];
	assign rem_diff = {1'b0, rem_sh} - {2'b00, opnd};

	always_comb
	begin
		if (is_div)
		begin
			if (!rem_diff[DATA_W+1])
				acc_next = {rem_diff[DATA_W-1:0], acc[DATA_W-2:0], 1'b1};
			else
				acc_next = {rem_sh[DATA_W-1:0], acc[DATA_W-2:0], 1'b0};
		end
		else
		begin
			acc_next = {add_sum, acc[DATA_W-1:1]}; // shift right with carry
		end
	end

	// working registers
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			acc <= {{DATA_W{1'b0}}, (is_div ? op_a : op_b)}; // dividend or multiplier
			opnd <= is_div ? op_b : op_a;
		end
		else if (step)
			acc <= acc_next;
	end

	// architectural hi/lo plus the mul-only low half
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hi_q <= '0;
			lo_q <= '0;
			pl_q <= '0;
		end
		else
		begin
			if (commit_hl)
			begin
				hi_q <= acc[2*DATA_W-1:DATA_W]; // product high or remainder
				lo_q <= acc[DATA_W-1:0];        // product low or quotient
			end
			if (commit_pl)
				pl_q <= acc[DATA_W-1:0];
		end
	end

	// forward the values being committed so the result reg catches them
	assign hi = commit_hl ? acc[2*DATA_W-1:DATA_W] : hi_q;
	assign lo = commit_hl ? acc[DATA_W-1:0] : lo_q;
	assign prod_lo = commit_pl ? acc[DATA_W-1:0] : pl_q;

endmodule

/* design/alu.sv */
`timescale 1ns/100ps

module alu import ex_pkg::*; #(
	parameter int DATA_W = EX_DATA_W
) (
	input  alu_ctl_t          ctl,
	input  logic [DATA_W-1:0] op_a,    // rs
	input  logic [DATA_W-1:0] op_b,    // rt, also the shift source
	input  logic [4:0]        shamt,
	input  logic [DATA_W-1:0] hi,      // from muldiv_core
	input  logic [DATA_W-1:0] lo,
	input  logic [DATA_W-1:0] prod_lo, // mul result, kept apart from lo
	output logic [DATA_W-1:0] y,
	output logic              branch
);

	logic [DATA_W-1:0] diff; // shared by sub, beq, bne
	logic              equal;

	assign diff = op_a - op_b;
	assign equal = (op_a == op_b);

	always_comb
	begin
		case (ctl)
			CTL_ADD:
				y = op_a + op_b;
			CTL_SUB, CTL_SUBNE:
				y = diff;
			CTL_SLT:
				y = DATA_W'(op_a < op_b); // unsigned compare here
			CTL_AND:
				y = op_a & op_b;
			CTL_OR:
				y = op_a | op_b;
			CTL_NOR:
				y = ~(op_a | op_b);
			CTL_SLL:
				y = op_b << shamt;
			CTL_SRL:
				y = op_b >> shamt; // logical, zero fill
			CTL_MFHI:
				y = hi;
			CTL_MFLO, CTL_MULT, CTL_DIV:
				y = lo; // product low half or quotient
			CTL_MUL:
				y = prod_lo;
			default:
				y = '0; // no-op and the spare code
		endcase
	end

	// beq on 0100, bne on 0110, nothing else branches
	assign branch = ((ctl == CTL_SUB) && equal) ||
		((ctl == CTL_SUBNE) && !equal);

endmodule

/* design/alu_control.sv */
`timescale 1ns/100ps

module alu_control import ex_pkg::*; (
	input  alu_op_t    alu_op, // class from main decoder
	input  logic [5:0] funct,  // r-type function field
	output alu_ctl_t   ctl     // 4 bit control code
);

	always_comb
	begin
		ctl = CTL_NOP; // also covers undefined funct, no latch
		case (alu_op)
			ALUOP_NONE:
				ctl = CTL_NOP; // j, jal pass through untouched
			ALUOP_ADD:
				ctl = CTL_ADD; // address calc and addi
			ALUOP_BEQ:
				ctl = CTL_SUB;
			ALUOP_BNE:
				ctl = CTL_SUBNE;
			ALUOP_SLT:
				ctl = CTL_SLT; // slti
			ALUOP_AND:
				ctl = CTL_AND;
			ALUOP_OR:
				ctl = CTL_OR;
			ALUOP_RTYPE:
			begin
				// only r-type looks at funct
				case (funct)
					FN_ADD:
						ctl = CTL_ADD;
					FN_SUB:
						ctl = CTL_SUB;
					FN_AND:
						ctl = CTL_AND;
					FN_OR:
						ctl = CTL_OR;
					FN_NOR:
						ctl = CTL_NOR;
					FN_SLT:
						ctl = CTL_SLT;
					FN_SLL:
						ctl = CTL_SLL; // shift amount from shamt
					FN_SRL:
						ctl = CTL_SRL;
					FN_JR:
						ctl = CTL_NOP; // jump target handled elsewhere
					FN_MULT:
						ctl = CTL_MULT;
					FN_MUL:
						ctl = CTL_MUL;
					FN_DIV:
						ctl = CTL_DIV;
					FN_MFHI:
						ctl = CTL_MFHI;
					FN_MFLO:
						ctl = CTL_MFLO;
					default:
						ctl = CTL_NOP; // unknown funct, result will read zero
				endcase
			end
			default:
				ctl = CTL_NOP;
		endcase
	end

endmodule

/* design/ex_pkg.sv */
package ex_pkg;

	// default datapath width, the top passes it down as DATA_W
	localparam int EX_DATA_W = 32;

	// operation class from the main decoder
	typedef enum logic [2:0] {
		ALUOP_ADD   = 3'b000, // addi, lw, sw
		ALUOP_RTYPE = 3'b001, // look at funct
		ALUOP_AND   = 3'b010,
		ALUOP_OR    = 3'b011,
		ALUOP_BEQ   = 3'b100, // subtract, branch on equal
		ALUOP_BNE   = 3'b101, // subtract, branch on not equal
		ALUOP_SLT   = 3'b110,
		ALUOP_NONE  = 3'b111  // j, jal
	} alu_op_t;

	// alu control codes, 0001 unused
	typedef enum logic [3:0] {
		CTL_ADD   = 4'b0000,
		CTL_SLL   = 4'b0010,
		CTL_SRL   = 4'b0011,
		CTL_SUB   = 4'b0100,
		CTL_SLT   = 4'b0101,
		CTL_SUBNE = 4'b0110,
		CTL_MFLO  = 4'b0111,
		CTL_AND   = 4'b1000,
		CTL_MUL   = 4'b1001, // low half only, hi/lo untouched
		CTL_OR    = 4'b1010,
		CTL_DIV   = 4'b1011,
		CTL_NOR   = 4'b1100,
		CTL_MULT  = 4'b1101, // full product into hi/lo
		CTL_MFHI  = 4'b1110,
		CTL_NOP   = 4'b1111
	} alu_ctl_t;

	// r-type function field values
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_MFHI = 6'b010000;
	localparam logic [5:0] FN_MFLO = 6'b010010;
	localparam logic [5:0] FN_MULT = 6'b011000;
	localparam logic [5:0] FN_MUL  = 6'b011001; // sits on the multu slot
	localparam logic [5:0] FN_DIV  = 6'b011010;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;

	// codes that go through the one-bit-per-clock datapath
	function automatic logic is_iterative(alu_ctl_t c);
		return (c == CTL_MULT) || (c == CTL_MUL) || (c == CTL_DIV);
	endfunction

endpackage
